//--- design/BottomPkg.sv
package BottomPkg;

	typedef logic [7:0]  Byte;       // One data byte
	typedef logic [15:0] Word;       // Address or register pair
	typedef logic [3:0]  RegId;      // Register code
	typedef logic [2:0]  BottomOp;   // Command operation code
	typedef logic [4:0]  IrqVec;     // Restart vector bits 7:3

	localparam RegId RegB   = 4'd0;
	localparam RegId RegC   = 4'd1;
	localparam RegId RegD   = 4'd2;
	localparam RegId RegE   = 4'd3;
	localparam RegId RegH   = 4'd4;
	localparam RegId RegL   = 4'd5;
	localparam RegId RegA   = 4'd7;  // Code 6 is reserved
	localparam RegId RegW   = 4'd8;
	localparam RegId RegZ   = 4'd9;
	localparam RegId RegSph = 4'd10;
	localparam RegId RegSpl = 4'd11;
	localparam RegId RegPch = 4'd12;
	localparam RegId RegPcl = 4'd13;

	localparam BottomOp OpNop   = 3'd0;
	localparam BottomOp OpLoad  = 3'd1;
	localparam BottomOp OpRead  = 3'd2;
	localparam BottomOp OpInc   = 3'd3;
	localparam BottomOp OpDec   = 3'd4;
	localparam BottomOp OpFetch = 3'd5;
	localparam BottomOp OpRst   = 3'd6;
	localparam BottomOp OpBit   = 3'd7;

	// Pair index is the register code with bit 0 dropped
	localparam logic [2:0] PairBc = 3'd0;
	localparam logic [2:0] PairDe = 3'd1;
	localparam logic [2:0] PairHl = 3'd2;
	localparam logic [2:0] PairWz = 3'd4;
	localparam logic [2:0] PairSp = 3'd5;
	localparam logic [2:0] PairPc = 3'd6;

	localparam Word DefResetPc = 16'h0100;
	localparam Word DefResetSp = 16'hFFFE;

	function automatic logic [2:0] pairOf(RegId r);
		return r[3:1];
	endfunction

	function automatic logic isPairOp(BottomOp op);
		return (op == OpInc) || (op == OpDec);
	endfunction

endpackage

//--- design/RegFile.sv
`timescale 1ns/1ps

module RegFile (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Byte     cmdData,
	input  BottomPkg::Word     incDecValue,
	output BottomPkg::Word     bcPair,
	output BottomPkg::Word     dePair,
	output BottomPkg::Word     hlPair,
	output BottomPkg::Byte     regA
);
	import BottomPkg::*;

	Byte regB;
	Byte regC;
	Byte regD;
	Byte regE;
	Byte regH;
	Byte regL;

	logic loadStrobe;
	logic pairStrobe;

	assign loadStrobe = cmdValid && (cmdOp == OpLoad);
	assign pairStrobe = cmdValid && isPairOp(cmdOp);   // A is not part of a pair

	always_ff @(posedge CLK) begin
		if (reset) begin
			regB <= '0;
			regC <= '0;
			regD <= '0;
			regE <= '0;
			regH <= '0;
			regL <= '0;
			regA <= '0;
		end else if (loadStrobe) begin
			case (cmdReg)
				RegB:    regB <= cmdData;
				RegC:    regC <= cmdData;
				RegD:    regD <= cmdData;
				RegE:    regE <= cmdData;
				RegH:    regH <= cmdData;
				RegL:    regL <= cmdData;
				RegA:    regA <= cmdData;
				default: ;                   // Not ours or reserved
			endcase
		end else if (pairStrobe) begin
			case (pairOf(cmdReg))
				PairBc:  {regB, regC} <= incDecValue;
				PairDe:  {regD, regE} <= incDecValue;
				PairHl:  {regH, regL} <= incDecValue;
				default: ;
			endcase
		end
	end

	// High byte first, as the pair sits on the address bus
	assign bcPair = {regB, regC};
	assign dePair = {regD, regE};
	assign hlPair = {regH, regL};

endmodule

//--- design/TempRegs.sv
`timescale 1ns/1ps

module TempRegs (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Byte     cmdData,
	input  BottomPkg::Word     incDecValue,
	output BottomPkg::Word     wzPair,
	output logic               tempC,
	output logic               tempH,
	output logic               tempN,
	output logic               tempZ
);
	import BottomPkg::*;

	Byte regW;
	Byte regZ;

	logic wzWrite;

	assign wzWrite = cmdValid && isPairOp(cmdOp) && (pairOf(cmdReg) == PairWz);

	always_ff @(posedge CLK) begin
		if (reset) begin
			regW <= '0;
			regZ <= '0;
		end else if (cmdValid && (cmdOp == OpLoad)) begin
			if (cmdReg == RegW)
				regW <= cmdData;
			if (cmdReg == RegZ)
				regZ <= cmdData;
		end else if (wzWrite) begin
			{regW, regZ} <= incDecValue;
		end
	end

	assign wzPair = {regW, regZ};

	// Flags saved in Z sit in the upper nibble, like the F register layout
	assign tempC = regZ[4];
	assign tempH = regZ[5];
	assign tempN = regZ[6];
	assign tempZ = regZ[7];

endmodule

//--- design/AddressRegs.sv
`timescale 1ns/1ps

module AddressRegs #(
	parameter BottomPkg::Word ResetSp = BottomPkg::DefResetSp,
	parameter BottomPkg::Word ResetPc = BottomPkg::DefResetPc
) (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Byte     cmdData,
	input  BottomPkg::Word     incDecValue,
	input  BottomPkg::IrqVec   irqVector,
	output BottomPkg::Word     spPair,
	output BottomPkg::Word     pcPair
);
	import BottomPkg::*;

	Word regSp;
	Word regPc;

	logic spWrite;
	logic pcWrite;
	Word  rstTarget;

	assign spWrite = isPairOp(cmdOp) && (pairOf(cmdReg) == PairSp);
	assign pcWrite = (cmdOp == OpFetch) ||
		(isPairOp(cmdOp) && (pairOf(cmdReg) == PairPc));

	assign rstTarget = {8'h00, irqVector, 3'b000};   // Restart page zero

	always_ff @(posedge CLK) begin
		if (reset) begin
			regSp <= ResetSp;
			regPc <= ResetPc;
		end else if (cmdValid) begin
			if (cmdOp == OpLoad) begin
				case (cmdReg)
					RegSph:  regSp[15:8] <= cmdData;
					RegSpl:  regSp[7:0]  <= cmdData;
					RegPch:  regPc[15:8] <= cmdData;
					RegPcl:  regPc[7:0]  <= cmdData;
					default: ;
				endcase
			end
			if (spWrite)
				regSp <= incDecValue;
			if (pcWrite)
				regPc <= incDecValue;          // Fetch increment or pair op
			if (cmdOp == OpRst)
				regPc <= rstTarget;
		end
	end

	assign spPair = regSp;
	assign pcPair = regPc;

endmodule

//--- design/IncDec.sv
`timescale 1ns/1ps

module IncDec (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Word     bcPair,
	input  BottomPkg::Word     dePair,
	input  BottomPkg::Word     hlPair,
	input  BottomPkg::Word     wzPair,
	input  BottomPkg::Word     spPair,
	input  BottomPkg::Word     pcPair,
	output BottomPkg::Word     incDecValue,
	output BottomPkg::Word     addr,
	output logic               addrValid
);
	import BottomPkg::*;

	logic [2:0] selIdx;
	Word        selPair;
	logic       selKnown;
	logic       addrStrobe;

	assign selIdx = (cmdOp == OpFetch) ? PairPc : pairOf(cmdReg);   // Fetch forces PC

	always_comb begin
		selKnown = 1'b1;
		case (selIdx)
			PairBc:  selPair = bcPair;
			PairDe:  selPair = dePair;
			PairHl:  selPair = hlPair;
			PairWz:  selPair = wzPair;
			PairSp:  selPair = spPair;
			PairPc:  selPair = pcPair;
			default: begin
				selPair  = '0;                   // Codes 6, 7, 14 and 15
				selKnown = 1'b0;
			end
		endcase
	end

	// Wraps modulo 2^16 in both directions
	assign incDecValue = (cmdOp == OpDec) ? selPair - 16'd1 : selPair + 16'd1;

	assign addrStrobe = cmdValid && selKnown && ((cmdOp == OpFetch) || isPairOp(cmdOp));

	always_ff @(posedge CLK) begin
		if (reset) begin
			addr      <= '0;
			addrValid <= 1'b0;
		end else begin
			addrValid <= addrStrobe;
			if (addrStrobe)
				addr <= selPair;                 // Value before the adjust
		end
	end

endmodule

//--- design/OperandLogic.sv
`timescale 1ns/1ps

module OperandLogic (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Byte     cmdData,
	input  BottomPkg::Word     bcPair,
	input  BottomPkg::Word     dePair,
	input  BottomPkg::Word     hlPair,
	input  BottomPkg::Word     wzPair,
	input  BottomPkg::Word     spPair,
	input  BottomPkg::Word     pcPair,
	input  BottomPkg::Byte     regA,
	output BottomPkg::Byte     operandA,
	output BottomPkg::Byte     operandB,
	output logic               operandValid,
	output logic               adjLow,
	output logic               adjHigh,
	output logic               adjBit
);
	import BottomPkg::*;

	Byte  selByte;
	logic selKnown;
	Byte  bitMask;
	logic opStrobe;

	always_comb begin
		selKnown = 1'b1;
		case (cmdReg)
			RegB:    selByte = bcPair[15:8];
			RegC:    selByte = bcPair[7:0];
			RegD:    selByte = dePair[15:8];
			RegE:    selByte = dePair[7:0];
			RegH:    selByte = hlPair[15:8];
			RegL:    selByte = hlPair[7:0];
			RegA:    selByte = regA;
			RegW:    selByte = wzPair[15:8];
			RegZ:    selByte = wzPair[7:0];
			RegSph:  selByte = spPair[15:8];
			RegSpl:  selByte = spPair[7:0];
			RegPch:  selByte = pcPair[15:8];
			RegPcl:  selByte = pcPair[7:0];
			default: begin
				selByte  = '0;
				selKnown = 1'b0;
			end
		endcase
	end

	assign bitMask  = Byte'(1) << cmdData[2:0];   // One-hot bit index
	assign opStrobe = cmdValid && selKnown && ((cmdOp == OpRead) || (cmdOp == OpBit));

	always_ff @(posedge CLK) begin
		if (reset) begin
			operandA     <= '0;
			operandB     <= '0;
			operandValid <= 1'b0;
		end else begin
			operandValid <= opStrobe;
			if (opStrobe) begin
				operandA <= selByte;
				operandB <= (cmdOp == OpBit) ? bitMask : regA;
			end
		end
	end

	// Decimal adjust hints straight from the accumulator
	assign adjLow  = regA[1] | regA[2] | regA[3];
	assign adjHigh = regA[5] | regA[6] | regA[7];
	assign adjBit  = regA[4] | regA[7];

endmodule

//--- design/Bottom.sv
`timescale 1ns/1ps

module Bottom #(
	parameter BottomPkg::Word ResetPc = BottomPkg::DefResetPc,
	parameter BottomPkg::Word ResetSp = BottomPkg::DefResetSp
) (
	input  logic               CLK,
	input  logic               reset,
	input  logic               cmdValid,
	input  BottomPkg::BottomOp cmdOp,
	input  BottomPkg::RegId    cmdReg,
	input  BottomPkg::Byte     cmdData,
	input  BottomPkg::IrqVec   irqVector,
	output BottomPkg::Word     addr,         // External address bus
	output logic               addrValid,
	output BottomPkg::Byte     operandA,     // ALU operand 1
	output BottomPkg::Byte     operandB,     // ALU operand 2
	output logic               operandValid,
	output logic               tempC,
	output logic               tempH,
	output logic               tempN,
	output logic               tempZ,
	output logic               adjLow,
	output logic               adjHigh,
	output logic               adjBit
);
	import BottomPkg::*;

	Word bcPair;
	Word dePair;
	Word hlPair;
	Word wzPair;
	Word spPair;
	Word pcPair;
	Byte regA;
	Word incDecValue;   // Shared writeback value

	RegFile regs (
		.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp),
		.cmdReg(cmdReg), .cmdData(cmdData), .incDecValue(incDecValue),
		.bcPair(bcPair), .dePair(dePair), .hlPair(hlPair), .regA(regA)
	);

	TempRegs tempRegs (
		.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp),
		.cmdReg(cmdReg), .cmdData(cmdData), .incDecValue(incDecValue),
		.wzPair(wzPair), .tempC(tempC), .tempH(tempH), .tempN(tempN), .tempZ(tempZ)
	);

	AddressRegs #(.ResetSp(ResetSp), .ResetPc(ResetPc)) addrRegs (
		.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp),
		.cmdReg(cmdReg), .cmdData(cmdData), .incDecValue(incDecValue),
		.irqVector(irqVector), .spPair(spPair), .pcPair(pcPair)
	);

	IncDec incDec (
		.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdReg(cmdReg),
		.bcPair(bcPair), .dePair(dePair), .hlPair(hlPair),
		.wzPair(wzPair), .spPair(spPair), .pcPair(pcPair),
		.incDecValue(incDecValue), .addr(addr), .addrValid(addrValid)
	);

	OperandLogic operands (
		.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp),
		.cmdReg(cmdReg), .cmdData(cmdData),
		.bcPair(bcPair), .dePair(dePair), .hlPair(hlPair),
		.wzPair(wzPair), .spPair(spPair), .pcPair(pcPair), .regA(regA),
		.operandA(operandA), .operandB(operandB), .operandValid(operandValid),
		.adjLow(adjLow), .adjHigh(adjHigh), .adjBit(adjBit)
	);

endmodule

//--- dv/Bottom_props.sv
`timescale 1ns/1ps

module BottomProps (
	input logic               CLK,
	input logic               reset,
	input logic               cmdValid,
	input BottomPkg::BottomOp cmdOp,
	input logic               addrValid,
	input logic               operandValid,
	input BottomPkg::Word     pcPair
);
	import BottomPkg::*;

	// A second strobe in a row needs a second command
	assert property (@(posedge CLK) disable iff (reset)
		addrValid && $past(addrValid) |-> $past(cmdValid))
		else $error("addrValid high twice without a new command");

	assert property (@(posedge CLK) disable iff (reset)
		operandValid && $past(operandValid) |-> $past(cmdValid))
		else $error("operandValid high twice without a new command");

	assert property (@(posedge CLK) $past(reset) |-> !addrValid && !operandValid)
		else $error("strobe high right after reset");

	assert property (@(posedge CLK) disable iff (reset)
		cmdValid && (cmdOp == OpFetch) |=> pcPair == $past(pcPair) + 16'd1)
		else $error("PC did not advance by one on fetch");

endmodule

bind Bottom BottomProps props (
	.CLK(CLK), .reset(reset), .cmdValid(cmdValid), .cmdOp(cmdOp),
	.addrValid(addrValid), .operandValid(operandValid), .pcPair(pcPair)
);

//--- dv/BottomTb.sv
`timescale 1ns/1ps

module BottomTb;
	import BottomPkg::*;

	localparam int StrobeTimeout = 8;   // Cycles to wait for a strobe

	typedef struct packed {
		BottomOp    op;
		RegId       rg;
		Byte        data;
		IrqVec      vec;
		logic       addrHit;
		Word        addr;
		logic       opHit;
		Byte        opA;
		Byte        opB;
		logic       flagChk;
		logic [6:0] flags;   // adjLow adjHigh adjBit tempZ tempN tempH tempC
	} Row;

	logic        CLK;
	logic        reset;
	logic        cmdValid;
	BottomOp     cmdOp;
	RegId        cmdReg;
	Byte         cmdData;
	IrqVec       irqVector;
	Word         addr;
	logic        addrValid;
	Byte         operandA;
	Byte         operandB;
	logic        operandValid;
	logic        tempC;
	logic        tempH;
	logic        tempN;
	logic        tempZ;
	logic        adjLow;
	logic        adjHigh;
	logic        adjBit;
	Row          rows[$];
	int          errors;
	logic [31:0] rngState;
	Byte         model[16];   // Expected register bytes by code

	Bottom #(.ResetPc(16'h0100), .ResetSp(16'hFFFE)) i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic giveUp(string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check(string name, logic [15:0] got, logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			giveUp($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic addRow(BottomOp op, RegId rg, Byte data, IrqVec vec, logic addrHit,
		Word addrExp, logic opHit, Byte opA, Byte opB, logic flagChk, logic [6:0] flags);
		rows.push_back('{op, rg, data, vec, addrHit, addrExp, opHit, opA, opB, flagChk, flags});
	endtask

	// Drive one command and return just after its accepting edge
	task automatic issue(BottomOp op, RegId rg, Byte data, IrqVec vec);
		cmdOp = op;
		cmdReg = rg;
		cmdData = data;
		irqVector = vec;
		cmdValid = 1'b1;
		@(posedge CLK);
		#5;
		cmdValid = 1'b0;
		cmdOp = OpNop;
	endtask

	task automatic idle();
		@(posedge CLK);
		#5;
	endtask

	task automatic waitStrobe(bit onOperand, string name);
		int n;
		n = 0;
		while (!(onOperand ? operandValid : addrValid) && n < StrobeTimeout) begin
			@(posedge CLK);
			#5;
			n++;
		end
		if (!(onOperand ? operandValid : addrValid))
			giveUp($sformatf("%s strobe never arrived", name));
		else if (n != 0)   // Due in the cycle after the accepting edge
			giveUp($sformatf("%s strobe came %0d cycles late", name, n));
	endtask

	task automatic applyRow(Row r);
		issue(r.op, r.rg, r.data, r.vec);
		if (r.addrHit) begin
			waitStrobe(1'b0, "addrValid");
			check("addr", addr, r.addr);
		end else
			check("addrValid", addrValid, 16'h0);
		if (r.opHit) begin
			waitStrobe(1'b1, "operandValid");
			check("operandA", operandA, r.opA);
			check("operandB", operandB, r.opB);
		end else
			check("operandValid", operandValid, 16'h0);
		if (r.flagChk)
			check("flags", {adjLow, adjHigh, adjBit, tempZ, tempN, tempH, tempC}, r.flags);
		idle();
	endtask

	task automatic buildTable();
		addRow(OpFetch, RegB,   8'h00, 5'h00, 1, 16'h0100, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpFetch, RegB,   8'h00, 5'h00, 1, 16'h0101, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpLoad,  RegA,   8'hA5, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b1110000);
		addRow(OpRead,  RegA,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hA5, 8'hA5, 0, 7'h00);
		addRow(OpLoad,  RegB,   8'h12, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegB,   8'h00, 5'h00, 0, 16'h0000, 1, 8'h12, 8'hA5, 0, 7'h00);
		addRow(OpLoad,  RegL,   8'hBC, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegL,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hBC, 8'hA5, 0, 7'h00);
		addRow(OpLoad,  4'd6,   8'h77, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  4'd6,   8'h00, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpLoad,  RegZ,   8'hF0, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b1111111);
		addRow(OpRead,  RegZ,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hF0, 8'hA5, 0, 7'h00);
		// Pair adjust puts the old value on the bus
		addRow(OpInc,   RegC,   8'h00, 5'h00, 1, 16'h1200, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegC,   8'h00, 5'h00, 0, 16'h0000, 1, 8'h01, 8'hA5, 0, 7'h00);
		addRow(OpDec,   RegD,   8'h00, 5'h00, 1, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegD,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hFF, 8'hA5, 0, 7'h00);
		addRow(OpRead,  RegE,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hFF, 8'hA5, 0, 7'h00);
		addRow(OpInc,   RegE,   8'h00, 5'h00, 1, 16'hFFFF, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegD,   8'h00, 5'h00, 0, 16'h0000, 1, 8'h00, 8'hA5, 0, 7'h00);
		addRow(OpDec,   RegH,   8'h00, 5'h00, 1, 16'h00BC, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegL,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hBB, 8'hA5, 0, 7'h00);
		addRow(OpInc,   RegZ,   8'h00, 5'h00, 1, 16'h00F0, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegZ,   8'h00, 5'h00, 0, 16'h0000, 1, 8'hF1, 8'hA5, 0, 7'h00);
		addRow(OpInc,   RegSph, 8'h00, 5'h00, 1, 16'hFFFE, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpInc,   RegSpl, 8'h00, 5'h00, 1, 16'hFFFF, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegSph, 8'h00, 5'h00, 0, 16'h0000, 1, 8'h00, 8'hA5, 0, 7'h00);
		addRow(OpDec,   RegSpl, 8'h00, 5'h00, 1, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRead,  RegSpl, 8'h00, 5'h00, 0, 16'h0000, 1, 8'hFF, 8'hA5, 0, 7'h00);
		addRow(OpInc,   RegA,   8'h00, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpInc,   4'd14,  8'h00, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		// Restart vectors land in page zero
		addRow(OpRst,   RegB,   8'h00, 5'h07, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpFetch, RegB,   8'h00, 5'h00, 1, 16'h0038, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRst,   RegB,   8'h00, 5'h1F, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpFetch, RegB,   8'h00, 5'h00, 1, 16'h00F8, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpRst,   RegB,   8'h00, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpFetch, RegB,   8'h00, 5'h00, 1, 16'h0000, 0, 8'h00, 8'h00, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h00, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h01, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h09, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h02, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h12, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h04, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h1B, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h08, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h24, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h10, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h2D, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h20, 0, 7'h00);
		addRow(OpBit,   RegB,   8'h36, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h40, 0, 7'h00);
		addRow(OpBit,   RegB,   8'hFF, 5'h00, 0, 16'h0000, 1, 8'h12, 8'h80, 0, 7'h00);
		addRow(OpLoad,  RegA,   8'h10, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b0011111);
		addRow(OpLoad,  RegA,   8'h02, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b1001111);
		addRow(OpLoad,  RegZ,   8'h50, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b1000101);
		addRow(OpLoad,  RegA,   8'h80, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b0110101);
		addRow(OpLoad,  RegZ,   8'h20, 5'h00, 0, 16'h0000, 0, 8'h00, 8'h00, 1, 7'b0110010);
	endtask

	// Random loads into every register, then read each one back
	task automatic randomReadback();
		for (int round = 0; round < 3; round++) begin
			for (int r = 0; r < 14; r++) begin
				if (r != 6) begin
					rngState = xorshift(rngState);
					model[r] = rngState[7:0];
					issue(OpLoad, RegId'(r), rngState[7:0], 5'h00);
					idle();
				end
			end
			for (int r = 0; r < 14; r++) begin
				if (r != 6) begin
					issue(OpRead, RegId'(r), 8'h00, 5'h00);
					waitStrobe(1'b1, "operandValid");
					check("operandA", operandA, model[r]);
					check("operandB", operandB, model[RegA]);
					idle();
				end
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		cmdValid = 1'b0;
		cmdOp = OpNop;
		cmdReg = RegB;
		cmdData = '0;
		irqVector = '0;
		errors = 0;
		rngState = 32'd58028;
		buildTable();
		repeat (16) @(posedge CLK);
		#5;
		reset = 1'b0;
		// Registered outputs and flags start from zero
		check("addr", addr, 16'h0000);
		check("addrValid", addrValid, 16'h0);
		check("operandA", operandA, 16'h0000);
		check("operandB", operandB, 16'h0000);
		check("operandValid", operandValid, 16'h0);
		check("flags", {adjLow, adjHigh, adjBit, tempZ, tempN, tempH, tempC}, 16'h0000);
		foreach (rows[i])
			applyRow(rows[i]);
		randomReadback();
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- tb.f
design/BottomPkg.sv
design/RegFile.sv
design/TempRegs.sv
design/AddressRegs.sv
design/IncDec.sv
design/OperandLogic.sv
design/Bottom.sv
dv/Bottom_props.sv
dv/BottomTb.sv

//--- Bender.yml
package:
  name: bottom

sources:
  - design/BottomPkg.sv
  - design/RegFile.sv
  - design/TempRegs.sv
  - design/AddressRegs.sv
  - design/IncDec.sv
  - design/OperandLogic.sv
  - design/Bottom.sv
  - target: simulation
    files:
      - dv/Bottom_props.sv
      - dv/BottomTb.sv
